// ==== design/cpuControl.sv ====
`timescale 1ns/1ps

module cpuControl (
   input  logic                   clk,
   input  logic                   reset,
   input  logic [rvPkg::xlen-1:0] rdata,
   input  rvPkg::memBusyT         busy,
   input  rvPkg::aluResT          aluRes,
   input  logic [rvPkg::xlen-1:0] rs1Data,
   input  logic [rvPkg::xlen-1:0] rs2Data,
   input  logic [rvPkg::xlen-1:0] storeData,
   input  logic [3:0]             storeMask,
   input  logic [rvPkg::xlen-1:0] loadData,
   output rvPkg::aluCmdT          aluCmd,
   output logic [4:0]             rs1Idx,
   output logic [4:0]             rs2Idx,
   output logic [4:0]             rdIdx,
   output logic                   writeEn,
   output logic [rvPkg::xlen-1:0] writeData,
   output logic [2:0]             funct3,
   output logic [1:0]             addrLow,
   output rvPkg::memOutT          bus
);
   import rvPkg::*;

   localparam logic [xlen-addrWidth-1:0] addrPad = '0;   // Upper address bits read 0

   logic [xlen-1:0]      instr;                     // Latched instruction word
   stateT                state;
   logic [addrWidth-1:0] pc;
   logic [addrWidth-1:0] addrReg;                   // Drives the bus address
   logic [addrWidth-1:0] pcPlus4;
   logic [addrWidth-1:0] pcPlusImm;
   logic [addrWidth-1:0] nextPc;
   logic [xlen-1:0]      pcRelImm;
   logic isLoad, isAluImm, isAuipc, isStore, isAluReg;
   logic isLui, isBranch, isJalr, isJal;
   logic isAlu;
   logic predicate;
   logic jump;

   assign rs1Idx  = instr[19:15];
   assign rs2Idx  = instr[24:20];
   assign rdIdx   = instr[11:7];
   assign funct3  = instr[14:12];
   assign addrLow = addrReg[1:0];
   assign isAlu   = isAluImm | isAluReg;

   // Instruction word arrives in waitInstr once rbusy drops
   always_ff @(posedge clk) begin
      if (state[waitInstrBit] && !busy.rbusy) begin
         instr <= rdata;
      end
   end

   // Opcode classes, latched together with the word
   always_ff @(posedge clk) begin
      if (!reset) begin
         {isLoad, isAluImm, isAuipc, isStore, isAluReg} <= '0;
         {isLui, isBranch, isJalr, isJal} <= '0;
      end else if (state[waitInstrBit] && !busy.rbusy) begin
         isLoad   <= (rdata[6:2] == opLoad);
         isAluImm <= (rdata[6:2] == opAluImm);
         isAuipc  <= (rdata[6:2] == opAuipc);
         isStore  <= (rdata[6:2] == opStore);
         isAluReg <= (rdata[6:2] == opAluReg);
         isLui    <= (rdata[6:2] == opLui);
         isBranch <= (rdata[6:2] == opBranch);
         isJalr   <= (rdata[6:2] == opJalr);
         isJal    <= (rdata[6:2] == opJal);
      end
   end

   // ************************************************
   // ALU command, rs1 always first operand
   assign aluCmd.in1    = rs1Data;
   assign aluCmd.in2    = (isAluReg | isBranch) ? rs2Data
                        : isStore ? immS(instr) : immI(instr);
   assign aluCmd.funct3 = funct3;
   assign aluCmd.sub    = instr[30] & instr[5];    // SUB only, not ADDI
   assign aluCmd.arith  = instr[30];                // SRA, SRAI
   assign aluCmd.wr     = state[executeBit] & isAlu;

   always_comb begin
      case (funct3)
         3'b000:  predicate = aluRes.eq;            // BEQ
         3'b001:  predicate = !aluRes.eq;           // BNE
         3'b100:  predicate = aluRes.lt;            // BLT
         3'b101:  predicate = !aluRes.lt;           // BGE
         3'b110:  predicate = aluRes.ltu;           // BLTU
         3'b111:  predicate = !aluRes.ltu;          // BGEU
         default: predicate = 1'b0;
      endcase
   end

   // PC-relative adder serves branches, JAL and AUIPC
   assign pcRelImm  = isJal ? immJ(instr) : isAuipc ? immU(instr) : immB(instr);
   assign pcPlusImm = pc + pcRelImm[addrWidth-1:0];
   assign pcPlus4   = pc + addrWidth'(4);
   assign jump      = isJal | (isBranch & predicate);
   assign nextPc    = isJalr ? {aluRes.plus[addrWidth-1:1], 1'b0}
                    : jump ? pcPlusImm : pcPlus4;

   // ************************************************
   // Write-back, one source per class
   assign writeData = (isLui            ? immU(instr)           : '0)
                    | (isAlu            ? aluRes.result         : '0)
                    | (isAuipc          ? {addrPad, pcPlusImm}  : '0)
                    | ((isJal | isJalr) ? {addrPad, pcPlus4}    : '0)
                    | (isLoad           ? loadData              : '0);

   assign writeEn = (state[executeBit] & (isLui | isAuipc | isJal | isJalr))
                  | (state[waitAluOrMemBit] & (isAlu | (isLoad & !busy.rbusy)));

   assign bus.addr  = {addrPad, addrReg};
   assign bus.wdata = storeData;
   assign bus.wmask = {4{state[storeBit]}} & storeMask;
   assign bus.rstrb = state[fetchInstrBit] | state[loadBit];

   // ************************************************
   // One-hot FSM
   always_ff @(posedge clk) begin
      if (!reset) begin
         state <= stateT'(1 << waitAluOrMemBit);    // Wait for a quiet bus first
         pc    <= resetAddr[addrWidth-1:0];
      end else begin
         case (1'b1)
            state[executeBit]: begin
               pc      <= nextPc;
               addrReg <= (isLoad | isStore) ? aluRes.plus[addrWidth-1:0] : nextPc;
               // Bits from storeBit down to fetchInstrBit
               state   <= {isStore, isAlu, isLoad, 1'b0, 1'b0, 1'b0,
                           !(isStore | isAlu | isLoad)};
            end
            state[waitInstrBit]: begin
               if (!busy.rbusy) state <= stateT'(1 << fetchRegsBit);
            end
            state[waitAluOrMemBit]: begin
               if (!(isAlu & aluRes.busy) && !busy.rbusy && !busy.wbusy) begin
                  addrReg <= pc;                    // Next fetch
                  state   <= stateT'(1 << fetchInstrBit);
               end
            end
            default: begin
               // fetch->waitInstr, fetchRegs->execute, load/store->wait
               state <= {1'b0, state[loadBit] | state[storeBit], 1'b0,
                         state[fetchRegsBit], 1'b0, state[fetchInstrBit], 1'b0};
            end
         endcase
      end
   end

   assert property (@(posedge clk) disable iff (!reset) $onehot(state))
      else $error("cpuControl: state not one-hot %b", state);

   // A cycle is either a read or a write on the shared bus
   assert property (@(posedge clk) disable iff (!reset) !(bus.rstrb && bus.wmask != 4'b0))
      else $error("cpuControl: read strobe and write mask together");

endmodule

// ==== design/femtoCore.sv ====
`timescale 1ns/1ps

module femtoCore (
   input  logic                   clk,
   input  logic                   reset,
   input  logic [rvPkg::xlen-1:0] rdata,
   input  rvPkg::memBusyT         busy,
   output rvPkg::memOutT          bus
);
   import rvPkg::*;

   aluCmdT          aluCmd;
   aluResT          aluRes;
   logic [4:0]      rs1Idx;
   logic [4:0]      rs2Idx;
   logic [4:0]      rdIdx;
   logic            writeEn;
   logic [xlen-1:0] writeData;
   logic [xlen-1:0] rs1Data;
   logic [xlen-1:0] rs2Data;
   logic [2:0]      funct3;                         // Access size and sign
   logic [1:0]      addrLow;
   logic [xlen-1:0] storeData;
   logic [3:0]      storeMask;
   logic [xlen-1:0] loadData;

   regFile registers (.clk, .rs1Idx, .rs2Idx, .rdIdx, .writeEn, .writeData,
                      .rs1Data, .rs2Data);

   rvAlu alu (.clk, .aluCmd, .aluRes);

   // Store lanes from rs2, load lanes from the bus
   memAlign align (.funct3, .addrLow, .storeSrc(rs2Data), .rdata,
                   .storeData, .storeMask, .loadData);

   cpuControl control (.clk, .reset, .rdata, .busy, .aluRes, .rs1Data, .rs2Data,
                       .storeData, .storeMask, .loadData, .aluCmd, .rs1Idx, .rs2Idx,
                       .rdIdx, .writeEn, .writeData, .funct3, .addrLow, .bus);

endmodule

// ==== design/memAlign.sv ====
`timescale 1ns/1ps

module memAlign (
   input  logic [2:0]             funct3,
   input  logic [1:0]             addrLow,
   input  logic [rvPkg::xlen-1:0] storeSrc,
   input  logic [rvPkg::xlen-1:0] rdata,
   output logic [rvPkg::xlen-1:0] storeData,
   output logic [3:0]             storeMask,
   output logic [rvPkg::xlen-1:0] loadData
);

   logic        byteAccess;                         // funct3[1:0] = 00
   logic        halfAccess;                         // funct3[1:0] = 01
   logic        loadSign;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;

   assign byteAccess = (funct3[1:0] == 2'b00);
   assign halfAccess = (funct3[1:0] == 2'b01);

   // ************************************************
   // Store side, byte or halfword copied into every lane it may land in
   assign storeData[7:0]   = storeSrc[7:0];
   assign storeData[15:8]  = addrLow[0] ? storeSrc[7:0] : storeSrc[15:8];
   assign storeData[23:16] = addrLow[1] ? storeSrc[7:0] : storeSrc[23:16];
   assign storeData[31:24] = addrLow[0] ? storeSrc[7:0]
                           : addrLow[1] ? storeSrc[15:8] : storeSrc[31:24];

   always_comb begin
      if (byteAccess) begin
         storeMask = 4'b0001 << addrLow;            // One lane
      end else if (halfAccess) begin
         storeMask = addrLow[1] ? 4'b1100 : 4'b0011;
      end else begin
         storeMask = 4'b1111;                       // Word
      end
   end

   // ************************************************
   // Load side, pick the lane then extend
   assign loadHalf = addrLow[1] ? rdata[31:16] : rdata[15:0];
   assign loadByte = addrLow[0] ? loadHalf[15:8] : loadHalf[7:0];

   // funct3[2] set means LBU / LHU
   assign loadSign = !funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]);

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte}
                   : halfAccess ? {{16{loadSign}}, loadHalf}
                   : rdata;

endmodule

// ==== design/regFile.sv ====
`timescale 1ns/1ps

module regFile (
   input  logic                   clk,
   input  logic [4:0]             rs1Idx,
   input  logic [4:0]             rs2Idx,
   input  logic [4:0]             rdIdx,
   input  logic                   writeEn,
   input  logic [rvPkg::xlen-1:0] writeData,
   output logic [rvPkg::xlen-1:0] rs1Data,
   output logic [rvPkg::xlen-1:0] rs2Data
);
   import rvPkg::*;

   logic [xlen-1:0] regs [32];                      // x1..x31, x0 never stored

   // Both ports read every cycle, data one cycle later
   always_ff @(posedge clk) begin
      rs1Data <= (rs1Idx == 5'd0) ? '0 : regs[rs1Idx];
      rs2Data <= (rs2Idx == 5'd0) ? '0 : regs[rs2Idx];
   end

   // Write lands at the edge
   always_ff @(posedge clk) begin
      if (writeEn && rdIdx != 5'd0) begin
         regs[rdIdx] <= writeData;                  // Writes to x0 dropped
      end
   end

   // A write-back source that is still unknown points at a sequencing bug
   assert property (@(posedge clk) writeEn |-> !$isunknown(writeData))
      else $error("regFile: unknown write data to x%0d", rdIdx);

endmodule

// ==== design/rvAlu.sv ====
`timescale 1ns/1ps

module rvAlu (
   input  logic          clk,
   input  rvPkg::aluCmdT aluCmd,
   output rvPkg::aluResT aluRes
);
   import rvPkg::*;

   logic [xlen-1:0] aluReg;                         // Result and shift register
   logic [4:0]      shamt;                          // Shift steps left to do
   logic [xlen-1:0] plus;
   logic [xlen:0]   minus;                          // One extra bit for the borrow
   logic            lt;
   logic            ltu;
   logic            eq;
   logic            busy;
   logic            isShift;

   // ************************************************
   // Adder and the shared subtract-compare

   assign plus = aluCmd.in1 + aluCmd.in2;

   // Top bit of the 33-bit in1 - in2 is the borrow
   assign minus = {1'b1, ~aluCmd.in2} + {1'b0, aluCmd.in1} + {{xlen{1'b0}}, 1'b1};

   assign ltu = minus[xlen];
   assign lt  = (aluCmd.in1[xlen-1] ^ aluCmd.in2[xlen-1]) ? aluCmd.in1[xlen-1]
                                                          : minus[xlen];
   assign eq  = (minus[xlen-1:0] == '0);

   assign isShift = (aluCmd.funct3[1:0] == 2'b01);  // SLL, SRL, SRA
   assign busy    = |shamt;

   // ************************************************
   // Result register and multi-cycle shifter

   always_ff @(posedge clk) begin
      if (aluCmd.wr) begin
         shamt <= isShift ? aluCmd.in2[4:0] : 5'd0;
         case (aluCmd.funct3)
            3'b000: aluReg <= aluCmd.sub ? minus[xlen-1:0] : plus;   // ADD, SUB
            3'b010: aluReg <= {{(xlen-1){1'b0}}, lt};                // SLT
            3'b011: aluReg <= {{(xlen-1){1'b0}}, ltu};               // SLTU
            3'b100: aluReg <= aluCmd.in1 ^ aluCmd.in2;               // XOR
            3'b110: aluReg <= aluCmd.in1 | aluCmd.in2;               // OR
            3'b111: aluReg <= aluCmd.in1 & aluCmd.in2;               // AND
            default: aluReg <= aluCmd.in1;                           // Shift start value
         endcase
      end else if (busy) begin
         shamt <= shamt - 5'd1;
         // One bit per cycle in the direction funct3[2] picks
         if (aluCmd.funct3[2]) begin
            aluReg <= {aluCmd.arith & aluReg[xlen-1], aluReg[xlen-1:1]};
         end else begin
            aluReg <= aluReg << 1;
         end
      end
   end

   // Outputs
   assign aluRes.result = aluReg;
   assign aluRes.plus   = plus;
   assign aluRes.eq     = eq;
   assign aluRes.lt     = lt;
   assign aluRes.ltu    = ltu;
   assign aluRes.busy   = busy;

   // Control must not start a new op while a shift is still running
   assert property (@(posedge clk) busy |-> !aluCmd.wr)
      else $error("rvAlu: write strobe during a running shift");

endmodule

// ==== design/rvPkg.sv ====
package rvPkg;

   localparam int xlen = 32;                        // Data word width
   localparam int addrWidth = 24;                   // Implemented address bits
   localparam logic [xlen-1:0] resetAddr = '0;      // First fetch after reset

   // Major opcodes, instruction bits 6:2
   localparam logic [4:0] opLoad   = 5'b00000;      // rd <- mem[rs1+immI]
   localparam logic [4:0] opAluImm = 5'b00100;      // rd <- rs1 op immI
   localparam logic [4:0] opAuipc  = 5'b00101;      // rd <- pc + immU
   localparam logic [4:0] opStore  = 5'b01000;      // mem[rs1+immS] <- rs2
   localparam logic [4:0] opAluReg = 5'b01100;      // rd <- rs1 op rs2
   localparam logic [4:0] opLui    = 5'b01101;      // rd <- immU
   localparam logic [4:0] opBranch = 5'b11000;      // if (rs1 op rs2) pc <- pc + immB
   localparam logic [4:0] opJalr   = 5'b11001;      // rd <- pc+4, pc <- rs1 + immI
   localparam logic [4:0] opJal    = 5'b11011;      // rd <- pc+4, pc <- pc + immJ

   // ************************************************
   // One-hot FSM state, one bit per state
   typedef logic [6:0] stateT;
   localparam int fetchInstrBit   = 0;              // Fetch strobe out
   localparam int waitInstrBit    = 1;              // Instruction in flight
   localparam int fetchRegsBit    = 2;              // Register read in flight
   localparam int executeBit      = 3;
   localparam int loadBit         = 4;              // Load strobe out
   localparam int waitAluOrMemBit = 5;              // Shift or memory wait
   localparam int storeBit        = 6;              // Write mask out

   // ************************************************
   typedef struct packed {
      logic [xlen-1:0] in1;
      logic [xlen-1:0] in2;
      logic [2:0]      funct3;
      logic            sub;                         // Subtract instead of add
      logic            arith;                       // Right shift keeps sign
      logic            wr;                          // Starts an operation
   } aluCmdT;

   typedef struct packed {
      logic [xlen-1:0] result;                      // ALU register
      logic [xlen-1:0] plus;                        // in1 + in2, also addresses
      logic            eq;
      logic            lt;
      logic            ltu;
      logic            busy;                        // Shift still running
   } aluResT;

   typedef struct packed {
      logic [xlen-1:0] addr;
      logic [xlen-1:0] wdata;
      logic [3:0]      wmask;
      logic            rstrb;
   } memOutT;

   typedef struct packed {
      logic rbusy;
      logic wbusy;
   } memBusyT;

   // Immediate formats, all sign extended from bit 31
   function automatic logic [xlen-1:0] immI(input logic [xlen-1:0] instr);
      return {{21{instr[31]}}, instr[30:20]};
   endfunction

   function automatic logic [xlen-1:0] immS(input logic [xlen-1:0] instr);
      return {{21{instr[31]}}, instr[30:25], instr[11:7]};
   endfunction

   function automatic logic [xlen-1:0] immB(input logic [xlen-1:0] instr);
      return {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   endfunction

   function automatic logic [xlen-1:0] immJ(input logic [xlen-1:0] instr);
      return {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
   endfunction

   function automatic logic [xlen-1:0] immU(input logic [xlen-1:0] instr);
      return {instr[31:12], 12'b0};
   endfunction

endpackage

// ==== files.f ====
design/rvPkg.sv
design/regFile.sv
design/rvAlu.sv
design/memAlign.sv
design/cpuControl.sv
design/femtoCore.sv
tests/tbMemModel.sv
tests/tbFemtoCore.sv

// ==== tests/cpu_golden.mem ====
// Words 0 on: program image. Word 0xBC: known word for loads
// Words 0xC0 on: store records, columns are byte address, masked data, write mask
@000
12345137 67810113 FFD00193 24000093 00310233 0040A023 40310233 0040A223
00317233 0040A423 00316233 0040A623 00314333 0060A823 0021A233 0040AA23
00313233 0040AC23 FFF14213 0040AE23 FFF13213 0240A023 00031213 0240A223
01131213 0240A423 00135213 0240A623 01F35213 0240A823 40135213 0240AA23
41135213 0240AC23 00331233 0240AE23 2F000393 00038203 0440A023 00238203
0440A223 00338203 0440A423 0033C203 0440A623 00039203 0440A823 00239203
0440AA23 0023D203 0440AC23 2E000513 00250023 002500A3 00250123 002501A3
00251223 00251323 00000413 00000493 00210463 00140413 00310463 00148493
00311463 00240413 00319463 00148493 0021C463 00440413 00314463 00148493
00315463 00840413 0021D463 00148493 00316463 01040413 0021E463 00148493
0021F463 02040413 00317463 00148493 008005EF 04040413 00000697 00C68667
08040413 0480AE23 0690A023 06B0A223 06C0A423 06D0A623 0000006F
@0BC
81F27F3C
@0C0
00000240 12345675 F 00000244 1234567B F 00000248 12345678 F
0000024C FFFFFFFD F 00000250 EDCBA985 F 00000254 00000001 F
00000258 00000001 F 0000025C EDCBA987 F 00000260 00000001 F
00000264 EDCBA985 F 00000268 530A0000 F 0000026C 76E5D4C2 F
00000270 00000001 F 00000274 F6E5D4C2 F 00000278 FFFFF6E5 F
0000027C A0000000 F 00000280 0000003C F 00000284 FFFFFFF2 F
00000288 FFFFFF81 F 0000028C 00000081 F 00000290 00007F3C F
00000294 FFFF81F2 F 00000298 000081F2 F 000002E0 00000078 1
000002E1 00007800 2 000002E2 00780000 4 000002E3 78000000 8
000002E4 00005678 3 000002E6 56780000 C 0000029C 00000000 F
000002A0 00000006 F 000002A4 00000154 F 000002A8 00000160 F
000002AC 00000158 F
FFFFFFFF 00000000 0

// ==== tests/tbFemtoCore.sv ====
`timescale 1ns/1ps

module tbFemtoCore;
   import rvPkg::*;

   localparam int recordBase   = 192;               // First golden store record word
   localparam int storeTimeout = 2000;              // Cycles allowed per store
   localparam int quietCycles  = 300;               // Watch for stray stores at the end
   localparam int numTests     = 5;

   logic        clk;
   logic        reset;
   logic [31:0] rdata;
   memBusyT     busy;
   memOutT      bus;
   logic        storeStrobe;
   logic [31:0] storeAddr;
   logic [31:0] storeData;
   logic [3:0]  storeMask;
   int          passCount;
   int          failCount;
   int          recIdx;
   bit          aborted;                            // Run stops early
   string       testNames [numTests] = '{"alu", "shift", "load", "store", "control"};
   int          testSizes [numTests] = '{9, 7, 7, 6, 5};

   femtoCore dut (.clk, .reset, .rdata, .busy, .bus);

   tbMemModel mem (.clk, .bus, .rdata, .busy, .storeStrobe, .storeAddr, .storeData,
                   .storeMask);

   always #50 clk = ~clk;                           // 100 ns period

   // Bytes outside the mask read as zero
   function automatic logic [31:0] maskBytes(input logic [31:0] data, input logic [3:0] mask);
      return data & {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
   endfunction

   task automatic waitStore(output bit got);
      got = 1'b0;
      for (int c = 0; c < storeTimeout && !got; c++) begin
         @(posedge clk);
         got = storeStrobe;
      end
   endtask

   task automatic compareValue(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
      if (got !== expected) begin
         $display("FAIL %s: got %h expected %h", name, got, expected);
         failCount++;
      end else begin
         passCount++;
      end
   endtask

   // ************************************************
   // One golden record against the next store
   task automatic checkRecord();
      logic [31:0] expAddr;
      logic [31:0] expData;
      logic [3:0]  expMask;
      bit          got;
      expAddr = mem.words[recordBase + 3*recIdx];
      expData = mem.words[recordBase + 3*recIdx + 1];
      expMask = mem.words[recordBase + 3*recIdx + 2][3:0];
      if (expAddr === 32'hffff_ffff) begin
         $display("Golden file ends before store record %0d", recIdx);
         failCount++;
         aborted = 1'b1;
      end else begin
         waitStore(got);
         if (!got) begin
            $display("Store %0d to %h never arrived", recIdx, expAddr);
            failCount++;
            aborted = 1'b1;
         end else begin
            compareValue("addr", storeAddr, expAddr);
            compareValue("wmask", {28'h0, storeMask}, {28'h0, expMask});
            compareValue("wdata", maskBytes(storeData, storeMask), expData);
         end
      end
      recIdx++;
   endtask

   initial begin
      int failsBefore;
      bit extra;
      clk       = 1'b0;
      reset     = 1'b0;
      passCount = 0;
      failCount = 0;
      recIdx    = 0;
      aborted   = 1'b0;
      extra     = 1'b0;
      repeat (3) @(posedge clk);
      #1 reset = 1'b1;

      for (int t = 0; t < numTests && !aborted; t++) begin
         failsBefore = failCount;
         for (int r = 0; r < testSizes[t] && !aborted; r++) begin
            checkRecord();
         end
         $display("Test %s: %s", testNames[t], (failCount == failsBefore) ? "ok" : "errors");
      end

      // No store may follow the last record
      if (!aborted) begin
         if (mem.words[recordBase + 3*recIdx] !== 32'hffff_ffff) begin
            $display("Golden file has more records than the program stores");
            failCount++;
         end
         for (int c = 0; c < quietCycles && !extra; c++) begin
            @(posedge clk);
            if (storeStrobe) begin
               extra = 1'b1;
               $display("Extra store to %h after the last record", storeAddr);
               failCount++;
            end
         end
         $display("Test end: %s", extra ? "errors" : "ok");
      end

      $display("Checks passed %0d, failed %0d", passCount, failCount);
      if (failCount == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// ==== tests/tbMemModel.sv ====
`timescale 1ns/1ps

module tbMemModel (
   input  logic           clk,
   input  rvPkg::memOutT  bus,
   output logic [31:0]    rdata,
   output rvPkg::memBusyT busy,
   output logic           storeStrobe,                  // One cycle per store
   output logic [31:0]    storeAddr,
   output logic [31:0]    storeData,
   output logic [3:0]     storeMask
);
   import rvPkg::*;

   localparam int memWords = 512;                   // Program, data and golden records

   logic [31:0] words [memWords];
   int          rStall;                             // Read busy cycles left
   int          wStall;                             // Write busy cycles left
   memOutT      req;                                // Bus sampled at the edge

   initial begin
      $readmemh("tests/cpu_golden.mem", words);
      void'($urandom(32'hd190_9950));              // Stall pattern seed
      rdata       = '0;
      busy        = '0;
      storeStrobe = 1'b0;
      storeAddr   = '0;
      storeData   = '0;
      storeMask   = '0;
      rStall      = 0;
      wStall      = 0;
      forever begin
         @(posedge clk);
         req = bus;
         if (rStall > 0) begin
            rStall--;
         end
         if (wStall > 0) begin
            wStall--;
         end
         if (req.rstrb) begin
            rStall = $urandom_range(3);             // 0 to 3 stall cycles
         end
         if (|req.wmask) begin
            wStall = $urandom_range(3);
            for (int b = 0; b < 4; b++) begin
               if (req.wmask[b]) begin
                  words[req.addr[10:2]][8*b +: 8] = req.wdata[8*b +: 8];
               end
            end
         end
         #1;                                        // Outputs change just after the edge
         busy.rbusy = (rStall > 0);
         busy.wbusy = (wStall > 0);
         if (req.rstrb) begin
            rdata = words[req.addr[10:2]];
         end
         storeStrobe = |req.wmask;
         storeAddr   = req.addr;
         storeData   = req.wdata;
         storeMask   = req.wmask;
      end
   end

endmodule
